//--- verilog/mult_consts.svh
`ifndef MULT_CONSTS_SVH
`define MULT_CONSTS_SVH

// operand and result widths.
`define MULT_WIDTH 16
`define PRODUCT_WIDTH 32

// one partial-product row per multiplier bit.
`define TREE_ROWS 16

// the tree is registered after this reduction layer.
`define TREE_SPLIT_LAYER 3

// rows left after the split layer (16, 11, 8, 6).
`define TREE_MID_ROWS 6

// rising edges after the sampling edge until the result is visible.
`define MULT_LATENCY 3

`endif

//--- verilog/multPkg.sv
`default_nettype none

`include "mult_consts.svh"

package multPkg;

    typedef logic [`MULT_WIDTH-1:0] operand_t;

    typedef logic [`PRODUCT_WIDTH-1:0] product_t;

    typedef struct packed {
        operand_t a;
        operand_t b;
    } operandPair_t;

    // redundant form of a product whose value is sum + carry.
    typedef struct packed {
        product_t sum;
        product_t carry;
    } carrySave_t;

    typedef product_t [`TREE_ROWS-1:0] ppRows_t;

    typedef product_t [`TREE_MID_ROWS-1:0] midRows_t;

endpackage

`default_nettype wire

//--- verilog/partialProductArray.sv
`timescale 1ns/1ns
`default_nettype none

`include "mult_consts.svh"

module partialProductArray (
    input  multPkg::operandPair_t operands,
    output multPkg::ppRows_t      rows
);

    localparam int padWidth = `PRODUCT_WIDTH - `MULT_WIDTH;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AND array
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    genvar i;
    generate
        for (i = 0; i < `TREE_ROWS; i++) begin : g_row
            multPkg::operand_t masked;
            multPkg::product_t extended;

            // row i is the multiplicand gated by multiplier bit i.
            assign masked = operands.a & {`MULT_WIDTH{operands.b[i]}};

            assign extended = {{padWidth{1'b0}}, masked};

            // weight of bit i.
            assign rows[i] = extended << i;
        end
    endgenerate

endmodule

`default_nettype wire

//--- verilog/csaLayer.sv
`timescale 1ns/1ns
`default_nettype none

module csaLayer #(
    parameter  int inRows  = 3,
    localparam int outRows = inRows - inRows / 3
) (
    input  multPkg::product_t [inRows-1:0]  rowsIn,
    output multPkg::product_t [outRows-1:0] rowsOut
);

    localparam int groups = inRows / 3;
    localparam int leftover = inRows % 3;

    genvar g;
    genvar r;
    generate
        // each group of three rows goes through a word-wide full adder.
        for (g = 0; g < groups; g++) begin : g_group
            multPkg::product_t x;
            multPkg::product_t y;
            multPkg::product_t z;
            multPkg::product_t majority;

            assign x = rowsIn[3*g];
            assign y = rowsIn[3*g+1];
            assign z = rowsIn[3*g+2];

            assign majority = (x & y) | (x & z) | (y & z);

            assign rowsOut[2*g] = x ^ y ^ z;

            // carries move one place up.
            // the dropped top bit is zero for any 16 x 16 product.
            assign rowsOut[2*g+1] = majority << 1;
        end

        // rows outside a full group wait for the next layer.
        for (r = 0; r < leftover; r++) begin : g_pass
            assign rowsOut[2*groups+r] = rowsIn[3*groups+r];
        end
    endgenerate

endmodule

`default_nettype wire

//--- verilog/wallaceTree.sv
`timescale 1ns/1ns
`default_nettype none

`include "mult_consts.svh"

module wallaceTree (
    input  logic                clk,
    input  logic                reset,
    input  multPkg::ppRows_t    rows,
    output multPkg::carrySave_t reduced
);

    // height left after a number of 3:2 layers.
    function automatic int rowsAfter(input int rows, input int layers);
        int height;
        height = rows;
        repeat (layers) begin
            height = height - height / 3;
        end
        return height;
    endfunction

    localparam int h1 = rowsAfter(`TREE_ROWS, 1);
    localparam int h2 = rowsAfter(`TREE_ROWS, 2);
    localparam int h3 = rowsAfter(`TREE_ROWS, `TREE_SPLIT_LAYER);
    localparam int h4 = rowsAfter(`TREE_MID_ROWS, 1);
    localparam int h5 = rowsAfter(`TREE_MID_ROWS, 2);
    localparam int h6 = rowsAfter(`TREE_MID_ROWS, 3);

    multPkg::product_t [h1-1:0] l1Rows;
    multPkg::product_t [h2-1:0] l2Rows;
    multPkg::product_t [h3-1:0] l3Rows;
    multPkg::product_t [h4-1:0] l4Rows;
    multPkg::product_t [h5-1:0] l5Rows;
    multPkg::product_t [h6-1:0] l6Rows;

    multPkg::midRows_t   midRows;
    multPkg::carrySave_t csReg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // first half reduces 16 rows to 6
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    csaLayer #(.inRows(`TREE_ROWS)) i_layer1 (
        .rowsIn  (rows),
        .rowsOut (l1Rows)
    );

    csaLayer #(.inRows(h1)) i_layer2 (
        .rowsIn  (l1Rows),
        .rowsOut (l2Rows)
    );

    csaLayer #(.inRows(h2)) i_layer3 (
        .rowsIn  (l2Rows),
        .rowsOut (l3Rows)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            midRows <= '0;
        end else begin
            midRows <= l3Rows;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // second half reduces 6 rows to 2
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    csaLayer #(.inRows(`TREE_MID_ROWS)) i_layer4 (
        .rowsIn  (midRows),
        .rowsOut (l4Rows)
    );

    csaLayer #(.inRows(h4)) i_layer5 (
        .rowsIn  (l4Rows),
        .rowsOut (l5Rows)
    );

    csaLayer #(.inRows(h5)) i_layer6 (
        .rowsIn  (l5Rows),
        .rowsOut (l6Rows)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            csReg <= '0;
        end else begin
            csReg.sum   <= l6Rows[0];
            csReg.carry <= l6Rows[1];
        end
    end

    assign reduced = csReg;

endmodule

`default_nettype wire

//--- verilog/rippleCarryAdder.sv
`timescale 1ns/1ns
`default_nettype none

`include "mult_consts.svh"

module rippleCarryAdder (
    input  logic                clk,
    input  logic                reset,
    input  multPkg::carrySave_t reduced,
    output multPkg::product_t   sum
);

    logic [`PRODUCT_WIDTH-1:0] carry;
    multPkg::product_t         sumBits;
    multPkg::product_t         sumReg;

    assign carry[0] = 1'b0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // full-adder chain from bit 0 up to the top bit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    genvar i;
    generate
        for (i = 0; i < `PRODUCT_WIDTH; i++) begin : g_cell
            logic x;
            logic y;

            assign x = reduced.sum[i];
            assign y = reduced.carry[i];

            assign sumBits[i] = x ^ y ^ carry[i];

            // no cell above the top bit takes its carry.
            if (i < `PRODUCT_WIDTH - 1) begin : g_carry
                assign carry[i+1] = (x & y) | (x & carry[i]) | (y & carry[i]);
            end
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (reset) begin
            sumReg <= '0;
        end else begin
            sumReg <= sumBits;
        end
    end

    assign sum = sumReg;

endmodule

`default_nettype wire

//--- verilog/wallaceMultiplier.sv
`timescale 1ns/1ns
`default_nettype none

`include "mult_consts.svh"

module wallaceMultiplier (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inValid,
    input  multPkg::operandPair_t operands,
    output logic                  outValid,
    output multPkg::product_t     product
);

    multPkg::operandPair_t    stage0Operands;
    logic                     stage0Valid;
    logic [`MULT_LATENCY-1:0] validChain;
    multPkg::ppRows_t         ppRows;
    multPkg::carrySave_t      reducedPair;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 0 and valid tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            stage0Operands <= '0;
            stage0Valid    <= 1'b0;
        end else begin
            if (inValid) begin
                stage0Operands <= operands;
            end
            stage0Valid <= inValid;
        end
    end

    // one flop per pipeline stage behind stage 0.
    // outValid lines up with the product register.
    always_ff @(posedge clk) begin
        if (reset) begin
            validChain <= '0;
        end else begin
            validChain <= {validChain[`MULT_LATENCY-2:0], stage0Valid};
        end
    end

    assign outValid = validChain[`MULT_LATENCY-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    partialProductArray i_partialProductArray (
        .operands (stage0Operands),
        .rows     (ppRows)
    );

    // two register stages inside.
    wallaceTree i_wallaceTree (
        .clk     (clk),
        .reset   (reset),
        .rows    (ppRows),
        .reduced (reducedPair)
    );

    rippleCarryAdder i_rippleCarryAdder (
        .clk     (clk),
        .reset   (reset),
        .reduced (reducedPair),
        .sum     (product)
    );

endmodule

`default_nettype wire

//--- testbench/multChecker.sv
`timescale 1ns/1ns
`default_nettype none

`include "mult_consts.svh"

module multChecker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inValid,
    input  multPkg::operandPair_t operands,
    input  logic [127:0]          testName,
    input  logic                  outValid,
    input  multPkg::product_t     product,
    output int                    passCount,
    output int                    errorCount,
    output int                    pendingCount
);

    // a result turns visible after the third edge behind its sampling edge,
    // so it is seen at the fourth.
    localparam int seenAfter = `MULT_LATENCY + 1;

    typedef struct packed {
        logic [127:0]      name;
        multPkg::operand_t a;
        multPkg::operand_t b;
        int unsigned       issueCycle;
    } issued_t;

    issued_t     inFlight[$];
    int unsigned cycle;
    int          passes;
    int          errors;

    always @(posedge clk) begin : watch
        issued_t           head;
        issued_t           entry;
        multPkg::product_t wideA;
        multPkg::product_t wideB;
        multPkg::product_t expected;
        int unsigned       distance;

        cycle = cycle + 1;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // results leaving the pipeline
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        if (outValid === 1'b1) begin
            if (inFlight.size() == 0) begin
                $display("ERROR: outValid high with no test in flight, product %0d", product);
                errors = errors + 1;
            end else begin
                head = inFlight.pop_front();
                wideA = head.a;
                wideB = head.b;
                expected = wideA * wideB;
                distance = cycle - head.issueCycle;
                if (product !== expected) begin
                    $display("MISMATCH %s: expected %0d, actual %0d",
                        head.name, expected, product);
                    errors = errors + 1;
                end else if (distance != seenAfter) begin
                    $display("ERROR: %s came out %0d edges after sampling instead of %0d",
                        head.name, distance, seenAfter);
                    errors = errors + 1;
                end else begin
                    $display("pass %s: %0d x %0d = %0d", head.name, head.a, head.b, product);
                    passes = passes + 1;
                end
            end
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // operands entering the pipeline
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        if (reset === 1'b1) begin
            // anything still inside is lost.
            if (inFlight.size() != 0) begin
                $display("reset dropped %0d test(s) in flight", inFlight.size());
                inFlight.delete();
            end
        end else if (inValid === 1'b1) begin
            entry.name = testName;
            entry.a = operands.a;
            entry.b = operands.b;
            entry.issueCycle = cycle;
            inFlight.push_back(entry);
        end

        passCount <= passes;
        errorCount <= errors;
        pendingCount <= inFlight.size();
    end

endmodule

`default_nettype wire

//--- testbench/wallaceMultiplier_sva.sv
`timescale 1ns/1ns
`default_nettype none

`include "mult_consts.svh"

module wallaceMultiplier_sva (
    input logic              clk,
    input logic              reset,
    input logic              inValid,
    input logic              outValid,
    input multPkg::product_t product
);

    // outValid is sampled one edge after it turns visible.
    localparam int seenAfter = `MULT_LATENCY + 1;

    int failureCount = 0;

    property quietAfterReset;
        @(posedge clk) reset |=> !outValid;
    endproperty

    property validFollowsInput;
        @(posedge clk) disable iff (reset) outValid == $past(inValid, seenAfter);
    endproperty

    property productKnown;
        @(posedge clk) disable iff (reset) outValid |-> !$isunknown(product);
    endproperty

    quietAfterResetCheck: assert property (quietAfterReset)
        else begin
            failureCount++;
            $error("outValid was high in the cycle after reset");
        end

    validFollowsInputCheck: assert property (validFollowsInput)
        else begin
            failureCount++;
            $error("outValid does not follow inValid from the pipeline latency earlier");
        end

    productKnownCheck: assert property (productKnown)
        else begin
            failureCount++;
            $error("product has unknown bits while outValid is high");
        end

endmodule

bind wallaceMultiplier wallaceMultiplier_sva i_wallaceMultiplierSva (
    .clk      (clk),
    .reset    (reset),
    .inValid  (inValid),
    .outValid (outValid),
    .product  (product)
);

`default_nettype wire

//--- testbench/tbWallaceMultiplier.sv
`timescale 1ns/1ns
`default_nettype none

`include "mult_consts.svh"

module tbWallaceMultiplier;

    localparam int clkPeriod = 4;
    localparam int resetCycles = 4;
    localparam int fixedEntries = 19;
    localparam int randomEntries = 20;
    localparam int entryCount = fixedEntries + randomEntries;
    // the entries sampled on the last three edges before a reset are still inside.
    localparam int droppedByReset = `MULT_LATENCY;
    localparam int expectedResults = entryCount - droppedByReset;

    typedef struct packed {
        logic [127:0]      name;
        multPkg::operand_t a;
        multPkg::operand_t b;
        logic [7:0]        gap;
        logic              resetBefore;
    } stimulus_t;

    logic                  clk;
    logic                  reset;
    logic                  inValid;
    multPkg::operandPair_t operands;
    logic                  outValid;
    multPkg::product_t     product;
    logic [127:0]          testName;

    int passCount;
    int errorCount;
    int pendingCount;

    stimulus_t stimulusTable [entryCount];
    logic      tableReady;
    int        idleCycles;

    initial begin
        clk = 1'b0;
    end

    always #(clkPeriod / 2) clk = ~clk;

    wallaceMultiplier i_wallaceMultiplier (
        .clk      (clk),
        .reset    (reset),
        .inValid  (inValid),
        .operands (operands),
        .outValid (outValid),
        .product  (product)
    );

    multChecker i_multChecker (
        .clk          (clk),
        .reset        (i_wallaceMultiplier.reset),
        .inValid      (i_wallaceMultiplier.inValid),
        .operands     (i_wallaceMultiplier.operands),
        .testName     (testName),
        .outValid     (i_wallaceMultiplier.outValid),
        .product      (i_wallaceMultiplier.product),
        .passCount    (passCount),
        .errorCount   (errorCount),
        .pendingCount (pendingCount)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic stimulus_t makeEntry(
        input logic [127:0]      name,
        input multPkg::operand_t a,
        input multPkg::operand_t b,
        input int                gap,
        input logic              resetBefore
    );
        stimulus_t entry;
        entry.name = name;
        entry.a = a;
        entry.b = b;
        entry.gap = 8'(gap);
        entry.resetBefore = resetBefore;
        return entry;
    endfunction

    task automatic loadTable;
        int          i;
        logic [31:0] state;
        logic [31:0] word;
        logic [7:0]  tens;
        logic [7:0]  ones;
        stimulusTable[0]  = makeEntry("zeroTimesZero", 16'h0000, 16'h0000, 0, 1'b0);
        stimulusTable[1]  = makeEntry("zeroTimesMax", 16'h0000, 16'hffff, 0, 1'b0);
        stimulusTable[2]  = makeEntry("maxTimesZero", 16'hffff, 16'h0000, 0, 1'b0);
        stimulusTable[3]  = makeEntry("oneTimesB", 16'h0001, 16'h1234, 0, 1'b0);
        stimulusTable[4]  = makeEntry("aTimesOne", 16'hbeef, 16'h0001, 0, 1'b0);
        stimulusTable[5]  = makeEntry("maxTimesMax", 16'hffff, 16'hffff, 0, 1'b0);
        stimulusTable[6]  = makeEntry("topBitSquared", 16'h8000, 16'h8000, 2, 1'b0);
        stimulusTable[7]  = makeEntry("lowTimesTopBit", 16'h0001, 16'h8000, 1, 1'b0);
        stimulusTable[8]  = makeEntry("singleBits", 16'h0010, 16'h0400, 3, 1'b0);
        stimulusTable[9]  = makeEntry("alternating", 16'haaaa, 16'h5555, 0, 1'b0);
        stimulusTable[10] = makeEntry("backToBackA", 16'h1234, 16'h5678, 0, 1'b0);
        stimulusTable[11] = makeEntry("backToBackB", 16'hffff, 16'h0002, 0, 1'b0);
        stimulusTable[12] = makeEntry("backToBackC", 16'h00ff, 16'hff00, 0, 1'b0);
        // only preResetA leaves the pipeline before the reset hits.
        stimulusTable[13] = makeEntry("preResetA", 16'h0101, 16'h0101, 0, 1'b0);
        stimulusTable[14] = makeEntry("preResetB", 16'hdead, 16'hbeef, 0, 1'b0);
        stimulusTable[15] = makeEntry("preResetC", 16'hcafe, 16'h0003, 0, 1'b0);
        stimulusTable[16] = makeEntry("preResetD", 16'h8001, 16'h8001, 0, 1'b0);
        stimulusTable[17] = makeEntry("afterResetA", 16'h00ff, 16'h0f0f, 0, 1'b1);
        stimulusTable[18] = makeEntry("afterResetB", 16'h7fff, 16'h0003, 5, 1'b0);

        state = 32'h5cbc;
        for (i = 0; i < randomEntries; i++) begin
            state = xorshift(state);
            word = state;
            state = xorshift(state);
            tens = 8'h30 + 8'(i / 10);
            ones = 8'h30 + 8'(i % 10);
            stimulusTable[fixedEntries + i] = makeEntry({"random", tens, ones},
                word[15:0], word[31:16], int'(state[1:0]), 1'b0);
        end

        // reset cycles count as idle time too.
        idleCycles = resetCycles;
        for (i = 0; i < entryCount; i++) begin
            idleCycles = idleCycles + int'(stimulusTable[i].gap);
            if (stimulusTable[i].resetBefore) begin
                idleCycles = idleCycles + resetCycles;
            end
        end
    endtask

    task automatic applyReset;
        inValid <= 1'b0;
        reset <= 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : mainSequence
        int idx;
        int assertFailures;
        reset = 1'b1;
        inValid = 1'b0;
        operands = '0;
        testName = '0;
        tableReady = 1'b0;
        loadTable();
        tableReady = 1'b1;

        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;

        for (idx = 0; idx < entryCount; idx++) begin
            repeat (stimulusTable[idx].gap) begin
                inValid <= 1'b0;
                @(posedge clk);
            end
            if (stimulusTable[idx].resetBefore) begin
                applyReset();
            end
            inValid <= 1'b1;
            operands.a <= stimulusTable[idx].a;
            operands.b <= stimulusTable[idx].b;
            testName <= stimulusTable[idx].name;
            @(posedge clk);
        end
        inValid <= 1'b0;

        @(posedge clk);
        while (pendingCount != 0) begin
            @(posedge clk);
        end
        // room for a stray pulse to show up.
        repeat (`MULT_LATENCY + 2) @(posedge clk);

        assertFailures = i_wallaceMultiplier.i_wallaceMultiplierSva.failureCount;
        if (passCount != expectedResults) begin
            $display("ERROR: %0d results passed but %0d were expected",
                passCount, expectedResults);
        end
        if (assertFailures != 0) begin
            $display("ERROR: %0d assertion failure(s) on the DUT ports", assertFailures);
        end
        $display("summary: %0d passed, %0d errors, %0d still in flight, %0d results expected",
            passCount, errorCount, pendingCount, expectedResults);
        if (errorCount == 0 && pendingCount == 0 && passCount == expectedResults
            && assertFailures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (tableReady === 1'b1);
        limit = entryCount + idleCycles + `MULT_LATENCY + 20;
        #(limit * clkPeriod);
        $display("ERROR: watchdog expired after %0d cycles, the run did not finish", limit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+verilog
verilog/multPkg.sv
verilog/partialProductArray.sv
verilog/csaLayer.sv
verilog/wallaceTree.sv
verilog/rippleCarryAdder.sv
verilog/wallaceMultiplier.sv
testbench/multChecker.sv
testbench/wallaceMultiplier_sva.sv
testbench/tbWallaceMultiplier.sv

//--- Bender.yml
package:
  name: wallace_multiplier

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/multPkg.sv
      - verilog/partialProductArray.sv
      - verilog/csaLayer.sv
      - verilog/wallaceTree.sv
      - verilog/rippleCarryAdder.sv
      - verilog/wallaceMultiplier.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/multChecker.sv
      - testbench/wallaceMultiplier_sva.sv
      - testbench/tbWallaceMultiplier.sv
